// File: logic/xix_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Index stack slice constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef XIX_CONSTS_SVH
`define XIX_CONSTS_SVH

`define XIX_XPT_W      5
`define XIX_XPT_FIRST  4          // First active step.
`define XIX_XPT_LAST   9          // Last active step.
`define XIX_BYTE_W     8
`define XIX_WORD_W     16
`define XIX_RAM_AW     8          // SP low bits index the RAM.
`define XIX_SP_RESET   16'hffff   // Same as a Z80 after reset.

`define XIX_LD_IX      2'd0
`define XIX_LD_IY      2'd1
`define XIX_LD_SP      2'd2

`endif

// File: logic/xix_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Index stack slice types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "xix_consts.svh"

package xix_pkg;

    // Step counter, 0 is idle and 4 to 9 are active.
    typedef logic [`XIX_XPT_W-1:0] xpt_t;

    typedef enum logic {
        OP_POP  = 1'b0,
        OP_PUSH = 1'b1
    } xix_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control strobes, one bit each
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic sel_ad_sp;   // SP on the RAM address.
        logic mem_rd;      // R0 read issue.
        logic mem_wr;
        logic inc_sp;
        logic dec_sp;
        logic wr_ix_lo;
        logic wr_ix_hi;
        logic wr_iy_lo;
        logic wr_iy_hi;
        logic out_hi;      // High byte onto write data.
        logic out_lo;      // Low byte onto write data.
        logic reset_xpt;
    } xix_ctrl_t;

    typedef struct packed {
        logic [`XIX_WORD_W-1:0] ix;
        logic [`XIX_WORD_W-1:0] iy;
        logic [`XIX_WORD_W-1:0] sp;
    } xix_regs_t;

endpackage

// File: logic/decoder_pop_xix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// POP IX/IY step decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decoder_pop_xix (
    input  xix_pkg::xpt_t      xpt,
    input  logic               enable,
    input  logic               is_y,
    output xix_pkg::xix_ctrl_t ctrl
);

    logic       grp_4_7;
    logic       grp_8_9;
    logic [9:4] st;
    logic       r0;
    logic       r2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Two-level state decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign grp_4_7 = enable && (xpt[4:2] == 3'b001);    // 0_01xx.
    assign grp_8_9 = enable && (xpt[4:1] == 4'b0100);   // 0_100x.

    assign st[4] = grp_4_7 && (xpt[1:0] == 2'b00);
    assign st[5] = grp_4_7 && (xpt[1:0] == 2'b01);
    assign st[6] = grp_4_7 && (xpt[1:0] == 2'b10);
    assign st[7] = grp_4_7 && (xpt[1:0] == 2'b11);
    assign st[8] = grp_8_9 && !xpt[0];
    assign st[9] = grp_8_9 && xpt[0];

    // R0 and R2 of both byte reads; 5 and 8 are the R1 wait and only need
    // the address held.
    assign r0 = st[4] | st[7];
    assign r2 = st[6] | st[9];

    always_comb begin
        ctrl           = '0;
        ctrl.sel_ad_sp = r0 | st[5] | st[8] | r2;   // States 4 to 9.
        ctrl.mem_rd    = r0;
        ctrl.inc_sp    = r2;

        // Low byte arrives in 6, high byte in 9.
        ctrl.wr_ix_lo  = st[6] && !is_y;
        ctrl.wr_iy_lo  = st[6] && is_y;
        ctrl.wr_ix_hi  = st[9] && !is_y;
        ctrl.wr_iy_hi  = st[9] && is_y;

        ctrl.reset_xpt = st[9];
    end

endmodule

// File: logic/decoder_push_xix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PUSH IX/IY step decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decoder_push_xix (
    input  xix_pkg::xpt_t      xpt,
    input  logic               enable,
    input  logic               is_y,
    output xix_pkg::xix_ctrl_t ctrl
);

    logic       grp_4_7;
    logic       grp_8_9;
    logic [9:4] st;
    logic       pre_dec;
    logic       wr_slot;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Two-level state decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign grp_4_7 = enable && (xpt[4:2] == 3'b001);
    assign grp_8_9 = enable && (xpt[4:1] == 4'b0100);

    assign st[4] = grp_4_7 && (xpt[1:0] == 2'b00);
    assign st[5] = grp_4_7 && (xpt[1:0] == 2'b01);
    assign st[6] = grp_4_7 && (xpt[1:0] == 2'b10);
    assign st[7] = grp_4_7 && (xpt[1:0] == 2'b11);
    assign st[8] = grp_8_9 && !xpt[0];
    assign st[9] = grp_8_9 && xpt[0];

    assign pre_dec = st[4] | st[7];   // SP moves before each byte.
    assign wr_slot = st[6] | st[9];

    always_comb begin
        ctrl           = '0;
        ctrl.sel_ad_sp = pre_dec | st[5] | st[8] | wr_slot;
        ctrl.dec_sp    = pre_dec;
        ctrl.mem_wr    = wr_slot;

        // High byte to SP-1 first, then low byte to SP-2.
        ctrl.out_hi    = st[6];
        ctrl.out_lo    = st[9];

        ctrl.reset_xpt = st[9];
    end

    // The byte source is picked downstream from the latched select.
    always_comb begin
        if (enable) begin
            assert (!$isunknown(is_y) || !wr_slot)
                else $error("push data select unknown during a write");
        end
    end

endmodule

// File: logic/xpt_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XPT step sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "xix_consts.svh"

module xpt_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  xix_pkg::xix_op_e   op,
    input  logic               is_y,
    output xix_pkg::xix_ctrl_t ctrl,
    output logic               is_y_q,
    output logic               busy,
    output logic               done
);

    import xix_pkg::*;

    xpt_t      xpt;
    xix_op_e   op_q;
    xix_ctrl_t ctrl_pop;
    xix_ctrl_t ctrl_push;
    logic      accept;

    assign busy   = (xpt != '0);
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xpt    <= '0;
            op_q   <= OP_POP;
            is_y_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= ctrl.reset_xpt;          // One cycle after the last step.
            if (accept) begin
                xpt    <= xpt_t'(`XIX_XPT_FIRST);
                op_q   <= op;
                is_y_q <= is_y;
            end else if (ctrl.reset_xpt) begin
                xpt <= '0;
            end else if (busy) begin
                xpt <= xpt + 1'b1;
            end
        end
    end

    decoder_pop_xix decoder_pop_xix_inst (
        .xpt    (xpt),
        .enable (op_q == OP_POP),
        .is_y   (is_y_q),
        .ctrl   (ctrl_pop)
    );

    decoder_push_xix decoder_push_xix_inst (
        .xpt    (xpt),
        .enable (op_q == OP_PUSH),
        .is_y   (is_y_q),
        .ctrl   (ctrl_push)
    );

    assign ctrl = xix_ctrl_t'(ctrl_pop | ctrl_push);   // Only one side is enabled.

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !start) else $error("start while busy");

    a_xpt_range: assert property (@(posedge clk) disable iff (!rst_n)
        (xpt == '0) || (xpt >= `XIX_XPT_FIRST && xpt <= `XIX_XPT_LAST))
        else $error("XPT out of range");

    a_sp_dir: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.inc_sp && ctrl.dec_sp)) else $error("SP inc and dec together");

endmodule

// File: logic/index_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IX, IY and SP registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "xix_consts.svh"

module index_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  xix_pkg::xix_ctrl_t      ctrl,
    input  logic                    is_y_q,
    input  logic                    ld,
    input  logic [1:0]              ld_sel,
    input  logic [`XIX_WORD_W-1:0]  ld_data,
    input  logic [`XIX_BYTE_W-1:0]  rdata,
    output xix_pkg::xix_regs_t      regs,
    output logic [`XIX_RAM_AW-1:0]  addr,
    output logic [`XIX_BYTE_W-1:0]  wdata,
    output logic                    we
);

    logic                   ld_ok;
    logic [`XIX_WORD_W-1:0] src;

    // sel_ad_sp covers every active step, so it doubles as busy here.
    assign ld_ok = ld && !ctrl.sel_ad_sp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs.ix <= '0;
            regs.iy <= '0;
            regs.sp <= `XIX_SP_RESET;
        end else begin
            if (ctrl.inc_sp) begin
                regs.sp <= regs.sp + 1'b1;
            end else if (ctrl.dec_sp) begin
                regs.sp <= regs.sp - 1'b1;
            end

            if (ctrl.wr_ix_lo) regs.ix[7:0]  <= rdata;
            if (ctrl.wr_ix_hi) regs.ix[15:8] <= rdata;
            if (ctrl.wr_iy_lo) regs.iy[7:0]  <= rdata;
            if (ctrl.wr_iy_hi) regs.iy[15:8] <= rdata;

            if (ld_ok) begin
                case (ld_sel)
                    `XIX_LD_IX: regs.ix <= ld_data;
                    `XIX_LD_IY: regs.iy <= ld_data;
                    `XIX_LD_SP: regs.sp <= ld_data;
                    default:    ;                         // Code 3 is ignored.
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RAM side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign addr  = ctrl.sel_ad_sp ? regs.sp[`XIX_RAM_AW-1:0] : '0;
    assign src   = is_y_q ? regs.iy : regs.ix;
    assign wdata = ctrl.out_hi ? src[15:8] :
                   ctrl.out_lo ? src[7:0]  : '0;
    assign we    = ctrl.mem_wr;

    a_one_byte_wr: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.wr_ix_lo, ctrl.wr_ix_hi, ctrl.wr_iy_lo, ctrl.wr_iy_hi}))
        else $error("more than one register byte write");

    // Loaded data must come from a read issued two cycles earlier.
    a_rd_to_wr: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.wr_ix_lo || ctrl.wr_ix_hi || ctrl.wr_iy_lo || ctrl.wr_iy_hi)
        |-> $past(ctrl.mem_rd, 2)) else $error("register byte load without R0");

endmodule

// File: logic/stack_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stack RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "xix_consts.svh"

module stack_ram (
    input  logic                   clk,
    input  logic [`XIX_RAM_AW-1:0] addr,
    input  logic [`XIX_BYTE_W-1:0] wdata,
    input  logic                   we,
    output logic [`XIX_BYTE_W-1:0] rdata
);

    logic [`XIX_BYTE_W-1:0] mem [0:(1 << `XIX_RAM_AW)-1];
    logic [`XIX_RAM_AW-1:0] addr_q;

    // Address captured in R0, data registered in R1, valid in R2.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        addr_q <= addr;
        rdata  <= mem[addr_q];
    end

endmodule

// File: logic/xix_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Index stack slice top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "xix_consts.svh"

module xix_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  xix_pkg::xix_op_e       op,
    input  logic                   is_y,
    input  logic                   ld,
    input  logic [1:0]             ld_sel,
    input  logic [`XIX_WORD_W-1:0] ld_data,
    output xix_pkg::xix_regs_t     regs,
    output logic                   busy,
    output logic                   done
);

    import xix_pkg::*;

    xix_ctrl_t              ctrl;
    logic                   is_y_q;
    logic [`XIX_RAM_AW-1:0] addr;
    logic [`XIX_BYTE_W-1:0] wdata;
    logic [`XIX_BYTE_W-1:0] rdata;
    logic                   we;

    xpt_sequencer xpt_sequencer_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .is_y   (is_y),
        .ctrl   (ctrl),
        .is_y_q (is_y_q),
        .busy   (busy),
        .done   (done)
    );

    index_regs index_regs_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .is_y_q  (is_y_q),
        .ld      (ld),
        .ld_sel  (ld_sel),
        .ld_data (ld_data),
        .rdata   (rdata),
        .regs    (regs),
        .addr    (addr),
        .wdata   (wdata),
        .we      (we)
    );

    stack_ram stack_ram_inst (
        .clk   (clk),
        .addr  (addr),
        .wdata (wdata),
        .we    (we),
        .rdata (rdata)
    );

endmodule

// File: dv/clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;              // 20 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: dv/xix_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Index stack slice testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "xix_consts.svh"

module xix_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import xix_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    xix_op_e                op;
    logic                   is_y;
    logic                   ld;
    logic [1:0]             ld_sel;
    logic [`XIX_WORD_W-1:0] ld_data;
    xix_regs_t              regs;
    logic                   busy;
    logic                   done;

    integer     seed = 32'h5dd5;
    xix_regs_t  m_regs;                      // Model of IX, IY and SP.
    logic [7:0] m_mem [0:255];
    xix_regs_t  exp_q [$];
    int         issued;
    int         checked;

    clk_gen clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    xix_top xix_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .op      (op),
        .is_y    (is_y),
        .ld      (ld),
        .ld_sel  (ld_sel),
        .ld_data (ld_data),
        .regs    (regs),
        .busy    (busy),
        .done    (done)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] want);
        if (got !== want) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, want);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_regs(input xix_regs_t want);
        check_val("ix", regs.ix, want.ix);
        check_val("iy", regs.iy, want.iy);
        check_val("sp", regs.sp, want.sp);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic void model_step(input xix_op_e cmd, input logic sel_y);
        logic [15:0] val;
        if (cmd == OP_PUSH) begin
            val = sel_y ? m_regs.iy : m_regs.ix;
            m_regs.sp = m_regs.sp - 16'd1;
            m_mem[m_regs.sp[7:0]] = val[15:8];   // High byte first, at SP-1.
            m_regs.sp = m_regs.sp - 16'd1;
            m_mem[m_regs.sp[7:0]] = val[7:0];
        end else begin
            val[7:0] = m_mem[m_regs.sp[7:0]];
            m_regs.sp = m_regs.sp + 16'd1;
            val[15:8] = m_mem[m_regs.sp[7:0]];
            m_regs.sp = m_regs.sp + 16'd1;
            if (sel_y) begin
                m_regs.iy = val;
            end else begin
                m_regs.ix = val;
            end
        end
    endfunction

    function automatic void model_load(input logic [1:0] sel, input logic [15:0] data);
        case (sel)
            `XIX_LD_IX: m_regs.ix = data;
            `XIX_LD_IY: m_regs.iy = data;
            `XIX_LD_SP: m_regs.sp = data;
            default:    ;
        endcase
    endfunction

    // Every bit of the byte address affects the stored value.
    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return (a * 8'd29) ^ 8'hc3;
    endfunction

    task automatic load_reg(input logic [1:0] sel, input logic [15:0] data);
        @(posedge clk);
        #1;
        ld      = 1'b1;
        ld_sel  = sel;
        ld_data = data;
        @(posedge clk);
        #1;
        ld = 1'b0;
        model_load(sel, data);
        @(negedge clk);
        check_regs(m_regs);
    endtask

    task automatic run_cmd(input xix_op_e cmd, input logic sel_y);
        int n;
        model_step(cmd, sel_y);
        exp_q.push_back(m_regs);
        issued++;
        @(posedge clk);
        #1;
        start = 1'b1;
        op    = cmd;
        is_y  = sel_y;
        @(posedge clk);
        #1;
        start = 1'b0;
        n = 0;
        while (checked != issued && n < 30) begin
            @(posedge clk);
            n++;
        end
        if (checked != issued) begin
            abort_run("Timeout: the result of a command was never checked");
        end
    endtask

    // Push both, pop both crossed, so IX and IY swap.
    task automatic wrap_case(input logic [15:0] sp_val);
        logic [31:0] r;
        load_reg(`XIX_LD_SP, sp_val);
        r = $random(seed);
        load_reg(`XIX_LD_IX, r[15:0]);
        load_reg(`XIX_LD_IY, r[31:16]);
        run_cmd(OP_PUSH, 1'b0);
        run_cmd(OP_PUSH, 1'b1);
        run_cmd(OP_POP, 1'b0);
        run_cmd(OP_POP, 1'b1);
        check_val("ix after swap", regs.ix, {16'd0, r[31:16]});
        check_val("sp after swap", regs.sp, {16'd0, sp_val});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Comparison
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : compare_proc
        xix_regs_t want;
        int        n;
        int        n_busy;
        forever begin
            @(negedge clk);
            if (rst_n && start && !busy) begin
                if (exp_q.size() == 0) begin
                    abort_run("A command started with no expected result queued");
                end
                want   = exp_q.pop_front();
                n      = 0;
                n_busy = 0;
                while (!done && n < 20) begin
                    @(negedge clk);
                    n++;
                    if (busy) begin
                        n_busy++;
                    end
                end
                if (!done) begin
                    abort_run("Timeout: done never came after start");
                end
                check_val("start to done cycles", n, 7);
                check_val("busy cycles", n_busy, 6);
                check_val("busy with done", busy, 1'b0);
                check_regs(want);
                @(negedge clk);
                check_val("done after its cycle", done, 1'b0);
                checked++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : stimulus
        int          i;
        logic [7:0]  a;
        logic [31:0] r;
        start     = 1'b0;
        op        = OP_POP;
        is_y      = 1'b0;
        ld        = 1'b0;
        ld_sel    = 2'd0;
        ld_data   = '0;
        issued    = 0;
        checked   = 0;
        m_regs.ix = '0;
        m_regs.iy = '0;
        m_regs.sp = `XIX_SP_RESET;

        i = 0;
        while (rst_n !== 1'b1 && i < 10) begin
            @(posedge clk);
            i++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("Reset was never released");
        end
        @(negedge clk);
        check_regs(m_regs);
        check_val("busy after reset", busy, 1'b0);
        check_val("done after reset", done, 1'b0);

        // Byte order through PUSH IX and POP IY.
        load_reg(`XIX_LD_SP, 16'h8000);
        load_reg(`XIX_LD_IX, 16'h1234);
        run_cmd(OP_PUSH, 1'b0);
        check_val("sp after push", regs.sp, 16'h7ffe);
        run_cmd(OP_POP, 1'b1);
        check_val("iy after pop", regs.iy, 16'h1234);
        check_val("sp after pop", regs.sp, 16'h8000);

        // Fill the whole RAM so no later pop reads an unwritten byte.
        load_reg(`XIX_LD_SP, 16'h0000);
        for (i = 0; i < 128; i++) begin
            a = m_regs.sp[7:0];
            load_reg(`XIX_LD_IX, {fill_byte(a - 8'd1), fill_byte(a - 8'd2)});
            run_cmd(OP_PUSH, 1'b0);
        end

        wrap_case(16'h0000);
        wrap_case(16'h0001);
        wrap_case(16'hffff);
        wrap_case(16'h0100);
        wrap_case(16'hff01);

        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                load_reg((r[9:8] == 2'd3) ? `XIX_LD_IX : r[9:8], r[31:16]);
            end
            run_cmd(r[4] ? OP_PUSH : OP_POP, r[5]);
        end

        if (checked == issued && exp_q.size() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+logic
logic/xix_pkg.sv
logic/decoder_pop_xix.sv
logic/decoder_push_xix.sv
logic/xpt_sequencer.sv
logic/index_regs.sv
logic/stack_ram.sv
logic/xix_top.sv
dv/clk_gen.sv
dv/xix_tb.sv

// File: Bender.yml
package:
  name: xix_stack

sources:
  - include_dirs:
      - logic
    files:
      - logic/xix_pkg.sv
      - logic/decoder_pop_xix.sv
      - logic/decoder_push_xix.sv
      - logic/xpt_sequencer.sv
      - logic/index_regs.sv
      - logic/stack_ram.sv
      - logic/xix_top.sv
  - target: simulation
    files:
      - dv/clk_gen.sv
      - dv/xix_tb.sv
